//--- src/cmd_gen_pkg.sv
/*
 * Fixed geometry of the DDR2 command generator. Full-rate to half-rate ratio is 4
 * and the memory burst length is 8, so one local word covers four memory columns
 * and one memory command covers two local beats.
 */
`default_nettype none

package cmd_gen_pkg;

    // memory geometry
    localparam int CS_BITS         = 1;
    localparam int BANK_BITS       = 2;
    localparam int ROW_BITS        = 4;
    localparam int LOCAL_COL_BITS  = 4;

    // memory column is the local column with two zero bits appended below
    localparam int COL_BITS        = LOCAL_COL_BITS + 2;
    localparam int LOCAL_ADDR_BITS = CS_BITS + BANK_BITS + ROW_BITS + LOCAL_COL_BITS;

    localparam int SIZE_BITS       = 6;

    // one burst of 8 at ratio 4 spans two local beats
    localparam int BEATS_PER_BURST = 2;
    localparam int LOCAL_COL_STEP  = 2;

    // local address read as chip, bank, row, column
    typedef struct packed {
        logic [CS_BITS-1:0]        cs;
        logic [BANK_BITS-1:0]      bank;
        logic [ROW_BITS-1:0]       row;
        logic [LOCAL_COL_BITS-1:0] col;
    } addr_cbrc_t;

    // the same word read as chip, row, bank, column
    typedef struct packed {
        logic [CS_BITS-1:0]        cs;
        logic [ROW_BITS-1:0]       row;
        logic [BANK_BITS-1:0]      bank;
        logic [LOCAL_COL_BITS-1:0] col;
    } addr_crbc_t;

    // addr_order picks which view is valid for a given request
    typedef union packed {
        addr_cbrc_t cbrc;
        addr_crbc_t crbc;
    } local_addr_u;

    typedef struct packed {
        logic                 is_write;
        logic                 autopch;
        logic [SIZE_BITS-1:0] size;
        local_addr_u          addr;
    } local_req_t;

    // beats is 2 for a full burst and 1 for a trailing half burst
    typedef struct packed {
        logic                 is_write;
        logic                 autopch;
        logic [1:0]           beats;
        logic [CS_BITS-1:0]   cs;
        logic [BANK_BITS-1:0] bank;
        logic [ROW_BITS-1:0]  row;
        logic [COL_BITS-1:0]  col;
    } mem_cmd_t;

endpackage

`default_nettype wire

//--- src/addr_mapper.sv
/*
 * Input stage. Holds one accepted request until the splitter takes it.
 * Requests must have a nonzero size and start on an even local column.
 * addr_order must stay stable while a request is in flight.
 */
`default_nettype none

module addr_mapper (
    input  logic                              ctl_clk,
    input  logic                              ctl_reset_n,
    input  logic                              read_req,
    input  logic                              write_req,
    input  logic                              autopch,
    input  logic [cmd_gen_pkg::SIZE_BITS-1:0] size,
    input  cmd_gen_pkg::local_addr_u          addr,
    input  logic                              addr_order,
    input  logic                              take,
    output logic                              ready_out,
    output logic                              mapped_valid,
    output cmd_gen_pkg::mem_cmd_t             mapped_cmd,
    output logic [cmd_gen_pkg::SIZE_BITS-1:0] mapped_size
);
    import cmd_gen_pkg::*;

    logic                      full_q;
    logic                      accept;
    local_req_t                req_q;
    logic [LOCAL_COL_BITS-1:0] local_col;

    assign ready_out    = !full_q;
    assign mapped_valid = full_q;
    assign accept       = (read_req || write_req) && ready_out;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
            full_q <= 1'b0;
        else if (accept)
            full_q <= 1'b1;
        else if (take)
            full_q <= 1'b0;
    end

    always_ff @(posedge ctl_clk)
    begin
        if (accept)
        begin
            req_q.is_write <= write_req;
            req_q.autopch  <= autopch;
            req_q.size     <= size;
            req_q.addr     <= addr;
        end
    end

    // beats is filled in by the splitter
    always_comb
    begin
        mapped_cmd          = '0;
        mapped_cmd.is_write = req_q.is_write;
        mapped_cmd.autopch  = req_q.autopch;
        // chip select and column sit at the same bits under both orders
        mapped_cmd.cs       = req_q.addr.cbrc.cs;
        local_col           = req_q.addr.cbrc.col;
        if (addr_order)
        begin
            mapped_cmd.bank = req_q.addr.cbrc.bank;
            mapped_cmd.row  = req_q.addr.cbrc.row;
        end
        else
        begin
            mapped_cmd.bank = req_q.addr.crbc.bank;
            mapped_cmd.row  = req_q.addr.crbc.row;
        end
        mapped_cmd.col = {local_col, {(COL_BITS - LOCAL_COL_BITS){1'b0}}};
    end

    assign mapped_size = req_q.size;

    a_one_strobe: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        !(read_req && write_req));

    a_size_nonzero: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        accept |-> size != '0);

    // the column sits in the low bits under both orders
    a_col_even: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        accept |-> !addr.cbrc.col[0]);

endmodule

`default_nettype wire

//--- src/burst_splitter.sv
/*
 * Walks one mapped request a burst at a time. Each command covers two local
 * beats, or one for an odd tail. The column carries into row and bank in the
 * order that addr_order selects, and chip select wraps to zero.
 */
`default_nettype none

module burst_splitter (
    input  logic                              ctl_clk,
    input  logic                              ctl_reset_n,
    input  logic                              mapped_valid,
    input  cmd_gen_pkg::mem_cmd_t             mapped_cmd,
    input  logic [cmd_gen_pkg::SIZE_BITS-1:0] mapped_size,
    input  logic                              addr_order,
    input  logic                              slot_free,
    output logic                              take,
    output logic                              next_valid,
    output cmd_gen_pkg::mem_cmd_t             next_cmd
);
    import cmd_gen_pkg::*;

    logic                    busy_q;
    logic [SIZE_BITS-1:0]    remaining_q;
    mem_cmd_t                cur_q;
    mem_cmd_t                stepped;
    logic [LOCAL_COL_BITS:0] col_sum;
    logic                    issue;
    logic                    last;

    assign next_valid = busy_q;
    assign issue      = busy_q && slot_free;
    assign last       = remaining_q <= SIZE_BITS'(BEATS_PER_BURST);

    // a waiting request is loaded as soon as the current one issues its last burst
    assign take = mapped_valid && (!busy_q || (issue && last));

    always_comb
    begin
        next_cmd       = cur_q;
        next_cmd.beats = (remaining_q == SIZE_BITS'(1)) ? 2'd1 : 2'(BEATS_PER_BURST);
    end

    // top bit of the sum flags the column wrapping back to zero
    assign col_sum = {1'b0, cur_q.col[COL_BITS-1 -: LOCAL_COL_BITS]}
                   + (LOCAL_COL_BITS + 1)'(LOCAL_COL_STEP);

    always_comb
    begin
        stepped     = cur_q;
        stepped.col = {col_sum[LOCAL_COL_BITS-1:0], {(COL_BITS - LOCAL_COL_BITS){1'b0}}};
        if (col_sum[LOCAL_COL_BITS])
        begin
            if (addr_order)
            begin
                // chip-bank-row-column steps the row first
                stepped.row = cur_q.row + 1'b1;
                if (&cur_q.row)
                begin
                    stepped.bank = cur_q.bank + 1'b1;
                    if (&cur_q.bank)
                        stepped.cs = cur_q.cs + 1'b1;
                end
            end
            else
            begin
                stepped.bank = cur_q.bank + 1'b1;
                if (&cur_q.bank)
                begin
                    stepped.row = cur_q.row + 1'b1;
                    if (&cur_q.row)
                        stepped.cs = cur_q.cs + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            busy_q      <= 1'b0;
            remaining_q <= '0;
        end
        else if (take)
        begin
            busy_q      <= 1'b1;
            remaining_q <= mapped_size;
        end
        else if (issue)
        begin
            if (last)
                busy_q <= 1'b0;
            remaining_q <= remaining_q - SIZE_BITS'(BEATS_PER_BURST);
        end
    end

    always_ff @(posedge ctl_clk)
    begin
        if (take)
            cur_q <= mapped_cmd;
        else if (issue)
            cur_q <= stepped;
    end

    // a stalled command must not move, even if the mapper has a new request waiting
    a_next_stable: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        next_valid && !slot_free |=> next_valid && $stable(next_cmd));

endmodule

`default_nettype wire

//--- src/cmd_output_reg.sv
/*
 * Output stage. A single command register that holds under back-pressure.
 * slot_free looks at ready_in combinationally, so a drained slot refills at once.
 */
`default_nettype none

module cmd_output_reg (
    input  logic                  ctl_clk,
    input  logic                  ctl_reset_n,
    input  logic                  next_valid,
    input  cmd_gen_pkg::mem_cmd_t next_cmd,
    input  logic                  ready_in,
    output logic                  slot_free,
    output logic                  cmd_valid,
    output cmd_gen_pkg::mem_cmd_t cmd
);

    logic load;

    assign slot_free = !cmd_valid || ready_in;
    assign load      = next_valid && slot_free;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
            cmd_valid <= 1'b0;
        else if (slot_free)
            cmd_valid <= next_valid;
    end

    always_ff @(posedge ctl_clk)
    begin
        if (load)
            cmd <= next_cmd;
    end

    a_cmd_stable: assert property (@(posedge ctl_clk) disable iff (!ctl_reset_n)
        cmd_valid && !ready_in |=> cmd_valid && $stable(cmd));

endmodule

`default_nettype wire

//--- src/cmd_gen_top.sv
/*
 * DDR2 command generator, ratio 4 and burst length 8 only.
 * read_req and write_req must not be high together. The first command
 * appears after the third rising edge from acceptance at the earliest.
 */
`default_nettype none

module cmd_gen_top (
    input  logic                              ctl_clk,
    input  logic                              ctl_reset_n,
    input  logic                              read_req,
    input  logic                              write_req,
    input  logic                              autopch,
    input  logic [cmd_gen_pkg::SIZE_BITS-1:0] size,
    input  cmd_gen_pkg::local_addr_u          addr,
    input  logic                              addr_order,
    input  logic                              ready_in,
    output logic                              ready_out,
    output logic                              cmd_valid,
    output cmd_gen_pkg::mem_cmd_t             cmd
);
    import cmd_gen_pkg::*;

    logic                 mapped_valid;
    logic                 take;
    mem_cmd_t             mapped_cmd;
    logic [SIZE_BITS-1:0] mapped_size;
    logic                 next_valid;
    mem_cmd_t             next_cmd;
    logic                 slot_free;

    addr_mapper addr_mapper_i (
        .ctl_clk      (ctl_clk),
        .ctl_reset_n  (ctl_reset_n),
        .read_req     (read_req),
        .write_req    (write_req),
        .autopch      (autopch),
        .size         (size),
        .addr         (addr),
        .addr_order   (addr_order),
        .take         (take),
        .ready_out    (ready_out),
        .mapped_valid (mapped_valid),
        .mapped_cmd   (mapped_cmd),
        .mapped_size  (mapped_size)
    );

    burst_splitter burst_splitter_i (
        .ctl_clk      (ctl_clk),
        .ctl_reset_n  (ctl_reset_n),
        .mapped_valid (mapped_valid),
        .mapped_cmd   (mapped_cmd),
        .mapped_size  (mapped_size),
        .addr_order   (addr_order),
        .slot_free    (slot_free),
        .take         (take),
        .next_valid   (next_valid),
        .next_cmd     (next_cmd)
    );

    cmd_output_reg cmd_output_reg_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .next_valid  (next_valid),
        .next_cmd    (next_cmd),
        .ready_in    (ready_in),
        .slot_free   (slot_free),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd)
    );

endmodule

`default_nettype wire

//--- verif/cmd_gen_model.svh
/*
 * Reference model for the command generator testbench, included inside the
 * testbench module after the package import. Pushes onto expected_q.
 */
`ifndef CMD_GEN_MODEL_SVH
`define CMD_GEN_MODEL_SVH

localparam logic [16:0] LFSR_SEED = 17'd94987;

// 17 bit Fibonacci LFSR with taps 17 and 14, the new bit lands in bit 0
function automatic logic [16:0] lfsr_next(input logic [16:0] state);
    logic feedback;
    feedback = state[16] ^ state[13];
    return {state[15:0], feedback};
endfunction

// the local word counts up as one number in the order's field sequence, so a column
// wrap ripples into the next field up and chip select falls off the top
function automatic int expand_request(input local_req_t req, input logic order);
    logic [LOCAL_ADDR_BITS-1:0] word;
    local_addr_u                view;
    mem_cmd_t                   c;
    int                         remaining;
    int                         count;
    word      = req.addr;
    remaining = req.size;
    count     = 0;
    while (remaining > 0)
    begin
        view       = word;
        c          = '0;
        c.is_write = req.is_write;
        c.autopch  = req.autopch;
        c.beats    = (remaining == 1) ? 2'd1 : 2'd2;
        if (order)
        begin
            c.cs   = view.cbrc.cs;
            c.bank = view.cbrc.bank;
            c.row  = view.cbrc.row;
            c.col  = COL_BITS'(view.cbrc.col) * COL_BITS'(4);
        end
        else
        begin
            c.cs   = view.crbc.cs;
            c.bank = view.crbc.bank;
            c.row  = view.crbc.row;
            c.col  = COL_BITS'(view.crbc.col) * COL_BITS'(4);
        end
        expected_q.push_back(c);
        remaining = remaining - BEATS_PER_BURST;
        word      = word + LOCAL_ADDR_BITS'(LOCAL_COL_STEP);
        count     = count + 1;
    end
    return count;
endfunction

`endif

//--- verif/cmd_gen_tb.sv
/*
 * Testbench for the DDR2 command generator. Requests come from a table, the
 * included model predicts every command, and ready_in can follow an LFSR.
 */
`default_nettype none

module cmd_gen_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cmd_gen_pkg::*;

    typedef struct packed {
        local_req_t req;
        logic       order;
        logic       random_ready;
        logic       drain;
        logic [7:0] exp_count;
    } entry_t;

    localparam int CLK_PERIOD     = 40;
    localparam int DRIVE_DELAY    = 5;
    localparam int RESET_CYCLES   = 8;
    localparam int ACCEPT_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT  = 500;

    logic                 ctl_clk;
    logic                 ctl_reset_n;
    logic                 read_req;
    logic                 write_req;
    logic                 autopch;
    logic [SIZE_BITS-1:0] size;
    local_addr_u          addr;
    logic                 addr_order;
    logic                 ready_in;
    logic                 ready_out;
    logic                 cmd_valid;
    mem_cmd_t             cmd;

    mem_cmd_t    expected_q[$];
    entry_t      stim_table[$];
    logic        random_ready;
    logic [16:0] lfsr_q;
    logic        held_valid;
    mem_cmd_t    held_cmd;

    `include "cmd_gen_model.svh"

    cmd_gen_top cmd_gen_top_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .read_req    (read_req),
        .write_req   (write_req),
        .autopch     (autopch),
        .size        (size),
        .addr        (addr),
        .addr_order  (addr_order),
        .ready_in    (ready_in),
        .ready_out   (ready_out),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_cmd(input string name, input mem_cmd_t got, input mem_cmd_t exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            report_failure($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, exp));
    endtask

    function automatic entry_t make_entry(input logic is_write, input logic autopch_bit,
                                          input int beats, input logic [10:0] word,
                                          input logic order, input logic random_bit,
                                          input logic drain_bit, input int count);
        entry_t e;
        e.req.is_write = is_write;
        e.req.autopch  = autopch_bit;
        e.req.size     = SIZE_BITS'(beats);
        e.req.addr     = word;
        e.order        = order;
        e.random_ready = random_bit;
        e.drain        = drain_bit;
        e.exp_count    = 8'(count);
        return e;
    endfunction

    // holds the request until a negedge shows ready_out, which means the next edge takes it
    task automatic send_request(input entry_t e);
        int waited;
        int predicted;
        read_req  = !e.req.is_write;
        write_req = e.req.is_write;
        autopch   = e.req.autopch;
        size      = e.req.size;
        addr      = e.req.addr;
        waited    = 0;
        @(negedge ctl_clk);
        while (!ready_out)
        begin
            waited = waited + 1;
            if (waited > ACCEPT_TIMEOUT)
                report_failure("a request was not accepted before the timeout");
            @(negedge ctl_clk);
        end
        predicted = expand_request(e.req, e.order);
        check_count("table command count", predicted, e.exp_count);
        @(posedge ctl_clk);
        #(DRIVE_DELAY);
        read_req  = 1'b0;
        write_req = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(negedge ctl_clk);
        while (expected_q.size() != 0 || cmd_valid)
        begin
            waited = waited + 1;
            if (waited > DRAIN_TIMEOUT)
                report_failure("expected commands did not arrive before the timeout");
            @(negedge ctl_clk);
        end
        @(posedge ctl_clk);
        #(DRIVE_DELAY);
    endtask

    initial
    begin
        ctl_clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) ctl_clk = ~ctl_clk;
    end

    // random_ready is read at the edge, before the main process may change it
    initial
    begin
        logic take_random;
        ready_in = 1'b1;
        lfsr_q   = LFSR_SEED;
        forever
        begin
            @(posedge ctl_clk);
            take_random = random_ready;
            #(DRIVE_DELAY);
            if (take_random)
            begin
                lfsr_q   = lfsr_next(lfsr_q);
                ready_in = lfsr_q[0];
            end
            else
                ready_in = 1'b1;
        end
    end

    // outputs are sampled at the falling edge, where ready_in already holds its value for the next edge
    initial
    begin
        held_valid = 1'b0;
        forever
        begin
            @(negedge ctl_clk);
            if (ctl_reset_n)
            begin
                if (held_valid)
                begin
                    if (!cmd_valid)
                        report_failure("cmd_valid fell while ready_in was low");
                    check_cmd("cmd while stalled", cmd, held_cmd);
                end
                held_valid = cmd_valid && !ready_in;
                held_cmd   = cmd;
                if (cmd_valid && ready_in)
                begin
                    if (expected_q.size() == 0)
                        report_failure("a command arrived that no request accounts for");
                    else
                        check_cmd("cmd", cmd, expected_q.pop_front());
                end
            end
        end
    end

    initial
    begin
        read_req       = 1'b0;
        write_req      = 1'b0;
        autopch        = 1'b0;
        size           = '0;
        addr           = '0;
        addr_order     = 1'b1;
        random_ready   = 1'b0;
        ctl_reset_n    = 1'b0;

        // single commands and then a write of four bursts with an odd tail
        stim_table.push_back(make_entry(1'b0, 1'b1, 1, 11'h0A4, 1'b1, 1'b0, 1'b1, 1));
        stim_table.push_back(make_entry(1'b0, 1'b0, 2, 11'h536, 1'b1, 1'b0, 1'b1, 1));
        stim_table.push_back(make_entry(1'b1, 1'b0, 7, 11'h120, 1'b1, 1'b0, 1'b1, 4));
        // the same word near the last column carries into row and then into bank
        stim_table.push_back(make_entry(1'b0, 1'b0, 8, 11'h0AC, 1'b1, 1'b0, 1'b1, 4));
        stim_table.push_back(make_entry(1'b0, 1'b1, 8, 11'h0AC, 1'b0, 1'b0, 1'b1, 4));
        // ready_in from the LFSR
        stim_table.push_back(make_entry(1'b1, 1'b0, 20, 11'h3F0, 1'b0, 1'b1, 1'b1, 10));
        stim_table.push_back(make_entry(1'b0, 1'b1, 13, 11'h612, 1'b0, 1'b1, 1'b1, 7));
        // in back-to-back pairs the second request waits in the mapper
        stim_table.push_back(make_entry(1'b1, 1'b0, 6, 11'h044, 1'b1, 1'b0, 1'b0, 3));
        stim_table.push_back(make_entry(1'b0, 1'b0, 3, 11'h350, 1'b1, 1'b0, 1'b1, 2));
        stim_table.push_back(make_entry(1'b1, 1'b1, 9, 11'h2C8, 1'b1, 1'b1, 1'b0, 5));
        stim_table.push_back(make_entry(1'b0, 1'b0, 5, 11'h1DA, 1'b1, 1'b1, 1'b1, 3));
        // highest coordinates wrap chip select back to zero
        stim_table.push_back(make_entry(1'b0, 1'b0, 4, 11'h7FE, 1'b1, 1'b0, 1'b1, 2));
        stim_table.push_back(make_entry(1'b1, 1'b1, 4, 11'h7FE, 1'b0, 1'b0, 1'b1, 2));

        repeat (RESET_CYCLES) @(posedge ctl_clk);
        #(DRIVE_DELAY);
        ctl_reset_n = 1'b1;
        @(negedge ctl_clk);
        check_bit("ready_out", ready_out, 1'b1);
        check_bit("cmd_valid", cmd_valid, 1'b0);
        @(posedge ctl_clk);
        #(DRIVE_DELAY);

        foreach (stim_table[i])
        begin
            // addr_order may only change with nothing in flight
            if (stim_table[i].order !== addr_order)
            begin
                wait_drain();
                addr_order = stim_table[i].order;
            end
            random_ready = stim_table[i].random_ready;
            send_request(stim_table[i]);
            if (stim_table[i].drain)
                wait_drain();
        end

        wait_drain();
        random_ready = 1'b0;
        // a stray command in these idle cycles is caught by the collector
        repeat (10) @(posedge ctl_clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verif
src/cmd_gen_pkg.sv
src/addr_mapper.sv
src/burst_splitter.sv
src/cmd_output_reg.sv
src/cmd_gen_top.sv
verif/cmd_gen_tb.sv
